// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath widths
`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_NREG        32
`define CPU_OP_W        6
`define CPU_SUB_W       5

// first fetch address
`define CPU_RESET_PC    32'h0000_0000

// opcodes, bits 30:25
`define CPU_OP_ALU      6'b100000
`define CPU_OP_ADDI     6'b101000
`define CPU_OP_LW       6'b000010
`define CPU_OP_SW       6'b001010
`define CPU_OP_BEQ      6'b100110
`define CPU_OP_BNE      6'b100111

// alu sub-ops, bits 4:0
`define CPU_SUB_ADD     5'b00000
`define CPU_SUB_SUB     5'b00001
`define CPU_SUB_AND     5'b00010
`define CPU_SUB_XOR     5'b00011
`define CPU_SUB_OR      5'b00100
`define CPU_SUB_SLT     5'b00110

// operand source select
`define CPU_FWD_W       2
`define CPU_FWD_RF      2'd0
`define CPU_FWD_MEM     2'd1
`define CPU_FWD_WB      2'd2

`endif

// ==== src.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_ctrl_if.sv
verilog/cpu_control.sv
verilog/cpu_fetch.sv
verilog/cpu_regfile.sv
verilog/cpu_execute.sv
verilog/cpu_lsu.sv
verilog/cpu.sv
verif/tb_cpu_mem.sv
verif/tb_cpu.sv

// ==== verif/tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int RUN_TIMEOUT = 20000;

	logic clock;
	logic rst_n;
	logic backpressure;
	logic imem_valid;
	logic imem_ready;
	logic [`CPU_XLEN-1:0] imem_addr;
	logic [`CPU_XLEN-1:0] imem_rdata;
	logic dmem_valid;
	logic dmem_ready;
	logic dmem_write;
	logic [`CPU_XLEN-1:0] dmem_addr;
	logic [`CPU_XLEN-1:0] dmem_wdata;
	logic [`CPU_XLEN-1:0] dmem_rdata;
	logic alu_overflow;

	logic [`CPU_XLEN-1:0] prog [$];
	logic [`CPU_XLEN-1:0] exp_addr [$];
	logic [`CPU_XLEN-1:0] exp_data [$];
	int stores_seen;
	int ovf_count;
	int mismatch_errs;
	int other_errs;

	cpu i_cpu (
		.clock(clock),
		.rst_n(rst_n),
		.imem_valid(imem_valid),
		.imem_ready(imem_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid),
		.dmem_ready(dmem_ready),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.alu_overflow(alu_overflow)
	);

	tb_cpu_mem mem_model (
		.clock(clock),
		.backpressure(backpressure),
		.imem_valid(imem_valid),
		.imem_ready(imem_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid),
		.dmem_ready(dmem_ready),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [`CPU_XLEN-1:0] enc_r(input logic [`CPU_SUB_W-1:0] sub,
		input int rt, input int ra, input int rb);
		instr_t w;
		w = '0;
		w.r_form.opcode = `CPU_OP_ALU;
		w.r_form.rt = rt[4:0];
		w.r_form.ra = ra[4:0];
		w.r_form.rb = rb[4:0];
		w.r_form.sub_op = sub;
		return w;
	endfunction

	function automatic logic [`CPU_XLEN-1:0] enc_i(input logic [`CPU_OP_W-1:0] op,
		input int rt, input int ra, input int imm);
		instr_t w;
		w = '0;
		w.i_form.opcode = op;
		w.i_form.rt = rt[4:0];
		w.i_form.ra = ra[4:0];
		w.i_form.imm15 = imm[14:0];
		return w;
	endfunction

	// initial data memory contents
	function automatic logic [`CPU_XLEN-1:0] fill_word(input logic [`CPU_XLEN-1:0] addr);
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h0bad_f00d;
	endfunction

	function automatic logic signed_ovf(input longint s);
		longint lim;
		lim = 64'sh7fff_ffff;
		return (s > lim) || (s < -lim - 1);
	endfunction

	// architectural model fills the expected store lists and returns the overflow count
	function automatic int iss_run();
		logic [31:0] rf [32];
		logic [31:0] ram [256];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ea;
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [5:0] op;
		longint sa;
		longint sb;
		int rt;
		int ra;
		int rb;
		int steps;
		int ovf;
		for (int i = 0; i < 32; i++)
			rf[i] = '0;
		for (int i = 0; i < 256; i++)
			ram[i] = fill_word(i * 4);
		pc = 0;
		steps = 0;
		ovf = 0;
		while (pc < prog.size() * 4 && steps < RUN_TIMEOUT) begin
			w = prog[pc >> 2];
			op = w[30:25];
			rt = w[24:20];
			ra = w[19:15];
			rb = w[14:10];
			imm = {{17{w[14]}}, w[14:0]};
			a = rf[ra];
			b = rf[rt];
			ea = a + imm;
			next_pc = pc + 4;
			case (op)
				`CPU_OP_ALU: begin
					b = rf[rb];
					sa = $signed(a);
					sb = $signed(b);
					case (w[4:0])
						`CPU_SUB_ADD: begin
							ovf += signed_ovf(sa + sb);
							b = a + b;
						end
						`CPU_SUB_SUB: begin
							ovf += signed_ovf(sa - sb);
							b = a - b;
						end
						`CPU_SUB_AND: b = a & b;
						`CPU_SUB_OR:  b = a | b;
						`CPU_SUB_XOR: b = a ^ b;
						`CPU_SUB_SLT: b = (sa < sb) ? 32'd1 : 32'd0;
						default: b = '0;
					endcase
					if (rt != 0)
						rf[rt] = b;
				end
				`CPU_OP_ADDI: begin
					sa = $signed(a);
					sb = $signed(imm);
					ovf += signed_ovf(sa + sb);
					if (rt != 0)
						rf[rt] = ea;
				end
				`CPU_OP_LW: begin
					if (rt != 0)
						rf[rt] = ram[ea[9:2]];
				end
				`CPU_OP_SW: begin
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					ram[ea[9:2]] = b;
				end
				`CPU_OP_BEQ, `CPU_OP_BNE: begin
					if ((a == b) != (op == `CPU_OP_BNE))
						next_pc = pc + (imm << 2);
				end
				default: ;
			endcase
			pc = next_pc;
			steps++;
		end
		if (steps >= RUN_TIMEOUT) begin
			other_errs++;
			$display("reference model did not leave the program within %0d steps", steps);
		end
		return ovf;
	endfunction

	task automatic check_store_addr(input logic [`CPU_XLEN-1:0] got,
		input logic [`CPU_XLEN-1:0] exp);
		if (got !== exp) begin
			mismatch_errs++;
			$display("MISMATCH at %0t: store %0d address %h, expected %h", $time,
				stores_seen, got, exp);
		end
	endtask

	task automatic check_store_data(input logic [`CPU_XLEN-1:0] got,
		input logic [`CPU_XLEN-1:0] exp);
		if (got !== exp) begin
			mismatch_errs++;
			$display("MISMATCH at %0t: store %0d data %h, expected %h", $time,
				stores_seen, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp) begin
			mismatch_errs++;
			$display("MISMATCH at %0t: %s overflow pulses %0d, expected %0d", $time,
				name, got, exp);
		end
	endtask

	// every store transfer against the reference order
	always @(posedge clock) begin
		if (rst_n && dmem_valid && dmem_ready && dmem_write) begin
			if (exp_addr.size() == 0) begin
				other_errs++;
				$display("unexpected store to %h with data %h at %0t", dmem_addr,
					dmem_wdata, $time);
			end else begin
				check_store_addr(dmem_addr, exp_addr.pop_front());
				check_store_data(dmem_wdata, exp_data.pop_front());
			end
			stores_seen++;
		end
		if (rst_n && alu_overflow)
			ovf_count++;
	end

	task automatic store_regs(input int first, input int last, input int base);
		for (int r = first; r <= last; r++)
			prog.push_back(enc_i(`CPU_OP_SW, r, 0, base + (r - first) * 4));
	endtask

	task automatic gen_alu(input int n, input int nregs);
		logic [`CPU_SUB_W-1:0] subs [6];
		int kind;
		int rt;
		int ra;
		int rb;
		int imm;
		subs = '{`CPU_SUB_ADD, `CPU_SUB_SUB, `CPU_SUB_AND, `CPU_SUB_OR, `CPU_SUB_XOR,
			`CPU_SUB_SLT};
		for (int i = 0; i < n; i++) begin
			kind = $urandom % 7;
			rt = $urandom % (nregs + 1);
			ra = $urandom % (nregs + 1);
			rb = $urandom % (nregs + 1);
			imm = $urandom % 32768;
			if (kind == 6)
				prog.push_back(enc_i(`CPU_OP_ADDI, rt, ra, imm));
			else
				prog.push_back(enc_r(subs[kind], rt, ra, rb));
		end
	endtask

	task automatic build_load_use();
		int r;
		int other;
		int addr;
		prog.push_back(enc_i(`CPU_OP_ADDI, 1, 0, 123));
		prog.push_back(enc_i(`CPU_OP_SW, 1, 0, 'h200));
		prog.push_back(enc_i(`CPU_OP_LW, 2, 0, 'h200));
		prog.push_back(enc_r(`CPU_SUB_ADD, 3, 2, 2));
		prog.push_back(enc_i(`CPU_OP_SW, 3, 0, 'h204));
		// never written, returns the fill pattern
		prog.push_back(enc_i(`CPU_OP_LW, 4, 0, 'h300));
		prog.push_back(enc_i(`CPU_OP_ADDI, 5, 4, 7));
		prog.push_back(enc_i(`CPU_OP_SW, 5, 0, 'h208));
		prog.push_back(enc_i(`CPU_OP_LW, 6, 0, 'h204));
		prog.push_back(enc_i(`CPU_OP_SW, 6, 0, 'h20c));
		prog.push_back(enc_i(`CPU_OP_LW, 7, 0, 'h208));
		prog.push_back(enc_i(`CPU_OP_BEQ, 7, 5, 2));
		prog.push_back(enc_i(`CPU_OP_SW, 0, 0, 'h210));
		for (int i = 0; i < 16; i++) begin
			r = 1 + $urandom % 7;
			other = 1 + $urandom % 7;
			addr = 'h200 + ($urandom % 64) * 4;
			if ($urandom % 2) begin
				prog.push_back(enc_i(`CPU_OP_SW, r, 0, addr));
			end else begin
				prog.push_back(enc_i(`CPU_OP_LW, r, 0, addr));
				prog.push_back(enc_r(`CPU_SUB_ADD, other, r, other));
			end
		end
		store_regs(1, 7, 'h380);
	endtask

	task automatic build_branches();
		int loop_top;
		prog.push_back(enc_i(`CPU_OP_ADDI, 1, 0, 5));
		prog.push_back(enc_i(`CPU_OP_ADDI, 2, 0, 0));
		prog.push_back(enc_i(`CPU_OP_ADDI, 3, 0, 'h300));
		loop_top = prog.size();
		prog.push_back(enc_i(`CPU_OP_ADDI, 2, 2, 3));
		prog.push_back(enc_i(`CPU_OP_SW, 2, 3, 0));
		prog.push_back(enc_i(`CPU_OP_ADDI, 3, 3, 4));
		prog.push_back(enc_i(`CPU_OP_ADDI, 1, 1, -1));
		prog.push_back(enc_i(`CPU_OP_BNE, 0, 1, loop_top - prog.size()));
		// forward taken over two stores
		prog.push_back(enc_i(`CPU_OP_BEQ, 0, 1, 3));
		prog.push_back(enc_i(`CPU_OP_SW, 1, 0, 'h3f0));
		prog.push_back(enc_i(`CPU_OP_SW, 2, 0, 'h3f4));
		// beq then bne, both not taken
		prog.push_back(enc_i(`CPU_OP_BEQ, 0, 2, 2));
		prog.push_back(enc_i(`CPU_OP_SW, 2, 0, 'h3e0));
		prog.push_back(enc_i(`CPU_OP_BNE, 2, 2, 2));
		prog.push_back(enc_i(`CPU_OP_SW, 1, 0, 'h3e4));
		// flushed adds that would overflow
		prog.push_back(enc_i(`CPU_OP_ADDI, 4, 0, 'h3fff));
		repeat (17) prog.push_back(enc_r(`CPU_SUB_ADD, 4, 4, 4));
		prog.push_back(enc_i(`CPU_OP_BEQ, 0, 0, 3));
		prog.push_back(enc_r(`CPU_SUB_ADD, 5, 4, 4));
		prog.push_back(enc_r(`CPU_SUB_ADD, 6, 4, 4));
		prog.push_back(enc_i(`CPU_OP_ADDI, 7, 0, 3));
		loop_top = prog.size();
		prog.push_back(enc_i(`CPU_OP_ADDI, 6, 6, 1));
		prog.push_back(enc_i(`CPU_OP_BEQ, 7, 6, 2));
		prog.push_back(enc_i(`CPU_OP_BEQ, 0, 0, loop_top - prog.size()));
		prog.push_back(enc_i(`CPU_OP_SW, 6, 0, 'h3e8));
		store_regs(1, 7, 'h380);
	endtask

	task automatic build_overflow();
		int kind;
		int rt;
		int ra;
		int rb;
		prog.push_back(enc_i(`CPU_OP_ADDI, 1, 0, 'h3fff));
		repeat (16) prog.push_back(enc_r(`CPU_SUB_ADD, 1, 1, 1));
		prog.push_back(enc_i(`CPU_OP_ADDI, 2, 0, -16384));
		repeat (15) prog.push_back(enc_r(`CPU_SUB_ADD, 2, 2, 2));
		for (int i = 0; i < 40; i++) begin
			kind = $urandom % 3;
			rt = 1 + $urandom % 4;
			ra = 1 + $urandom % 4;
			rb = 1 + $urandom % 4;
			if (kind == 0)
				prog.push_back(enc_r(`CPU_SUB_ADD, rt, ra, rb));
			else if (kind == 1)
				prog.push_back(enc_r(`CPU_SUB_SUB, rt, ra, rb));
			else
				prog.push_back(enc_i(`CPU_OP_ADDI, rt, ra, $urandom % 32768));
		end
		store_regs(1, 4, 'h180);
	endtask

	task automatic run_once(input string name, input logic bp);
		int cycles;
		int exp_ovf;
		logic [`CPU_XLEN-1:0] end_addr;
		@(negedge clock);
		rst_n = 1'b0;
		backpressure = bp;
		for (int i = 0; i < 1024; i++)
			mem_model.imem[i] = (i < prog.size()) ? prog[i] : enc_i(`CPU_OP_ADDI, 0, 0, 0);
		for (int i = 0; i < 256; i++)
			mem_model.dmem[i] = fill_word(i * 4);
		exp_addr.delete();
		exp_data.delete();
		exp_ovf = iss_run();
		stores_seen = 0;
		ovf_count = 0;
		end_addr = prog.size() * 4 + 16;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		// done once fetch is four no-ops past the program
		cycles = 0;
		while (!(imem_valid && imem_addr == end_addr) && cycles < RUN_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (cycles >= RUN_TIMEOUT) begin
			other_errs++;
			$display("timeout: program %s with backpressure %0d never reached its end", name, bp);
		end
		@(negedge clock);
		if (exp_addr.size() != 0) begin
			other_errs++;
			$display("program %s with backpressure %0d: %0d expected stores never happened",
				name, bp, exp_addr.size());
		end
		check_count(ovf_count, exp_ovf, name);
	endtask

	task automatic run_program(input string name);
		run_once(name, 1'b0);
		run_once(name, 1'b1);
		prog.delete();
	endtask

	initial begin
		void'($urandom(4));
		rst_n = 1'b0;
		backpressure = 1'b0;
		mismatch_errs = 0;
		other_errs = 0;
		stores_seen = 0;
		ovf_count = 0;

		gen_alu(80, 31);
		store_regs(0, 31, 0);
		run_program("alu_random");

		prog.push_back(enc_i(`CPU_OP_ADDI, 1, 0, 7));
		prog.push_back(enc_r(`CPU_SUB_ADD, 2, 1, 1));
		prog.push_back(enc_r(`CPU_SUB_ADD, 3, 2, 1));
		prog.push_back(enc_r(`CPU_SUB_SUB, 1, 3, 2));
		prog.push_back(enc_r(`CPU_SUB_XOR, 2, 1, 3));
		gen_alu(60, 3);
		store_regs(0, 3, 'h100);
		run_program("dependent");

		build_load_use();
		run_program("load_use");
		build_branches();
		run_program("branches");
		build_overflow();
		run_program("overflow");

		$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verif/tb_cpu_mem.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu_mem (
	input logic clock,
	input logic backpressure,
	input logic imem_valid,
	output logic imem_ready,
	input logic [`CPU_XLEN-1:0] imem_addr,
	output logic [`CPU_XLEN-1:0] imem_rdata,
	input logic dmem_valid,
	output logic dmem_ready,
	input logic dmem_write,
	input logic [`CPU_XLEN-1:0] dmem_addr,
	input logic [`CPU_XLEN-1:0] dmem_wdata,
	output logic [`CPU_XLEN-1:0] dmem_rdata
);
	// loaded by the testbench while the DUT is in reset
	logic [`CPU_XLEN-1:0] imem [0:1023];
	logic [`CPU_XLEN-1:0] dmem [0:255];

	int i_left;
	int d_left;

	initial begin
		imem_ready = 1'b0;
		dmem_ready = 1'b0;
		i_left = 0;
		d_left = 0;
	end

	// read data valid in the transfer cycle
	assign imem_rdata = imem[imem_addr[11:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	// ready moves only on the falling edge, in random stretches
	always @(negedge clock) begin
		if (!backpressure) begin
			imem_ready = 1'b1;
			dmem_ready = 1'b1;
		end else begin
			if (i_left == 0) begin
				imem_ready = ($urandom % 3) != 0;
				i_left = 1 + $urandom % 4;
			end
			if (d_left == 0) begin
				dmem_ready = ($urandom % 3) != 0;
				d_left = 1 + $urandom % 4;
			end
			i_left = i_left - 1;
			d_left = d_left - 1;
		end
	end

	always @(posedge clock) begin
		if (dmem_valid && dmem_ready && dmem_write)
			dmem[dmem_addr[9:2]] <= dmem_wdata;
	end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu (
	input logic clock,
	input logic rst_n,

	output logic imem_valid,
	input logic imem_ready,
	output logic [`CPU_XLEN-1:0] imem_addr,
	input logic [`CPU_XLEN-1:0] imem_rdata,

	output logic dmem_valid,
	input logic dmem_ready,
	output logic dmem_write,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	input logic [`CPU_XLEN-1:0] dmem_rdata,

	output logic alu_overflow
);
	logic [`CPU_XLEN-1:0] branch_target;
	logic [`CPU_XLEN-1:0] rd_a_data;
	logic [`CPU_XLEN-1:0] rd_b_data;
	logic [`CPU_XLEN-1:0] ex_result;
	logic [`CPU_XLEN-1:0] ex_store_data;
	logic [`CPU_XLEN-1:0] mem_fwd_data;
	logic [`CPU_XLEN-1:0] wb_fwd_data;
	logic wr_en;
	logic [`CPU_REG_ADDR_W-1:0] wr_addr;
	logic [`CPU_XLEN-1:0] wr_data;

	cpu_ctrl_if ctrl_if ();

	cpu_control i_control (
		.clock(clock),
		.rst_n(rst_n),
		.ctrl(ctrl_if.control)
	);

	cpu_fetch i_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.ctrl(ctrl_if.datapath),
		.branch_target(branch_target),
		.imem_valid(imem_valid),
		.imem_ready(imem_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata)
	);

	// read ports are addressed from decode
	cpu_regfile i_regfile (
		.clock(clock),
		.rst_n(rst_n),
		.rd_a_addr(ctrl_if.rs_a),
		.rd_b_addr(ctrl_if.rs_b),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	cpu_execute i_execute (
		.clock(clock),
		.rst_n(rst_n),
		.ctrl(ctrl_if.datapath),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.mem_fwd_data(mem_fwd_data),
		.wb_fwd_data(wb_fwd_data),
		.branch_target(branch_target),
		.alu_overflow(alu_overflow),
		.ex_result(ex_result),
		.ex_store_data(ex_store_data)
	);

	cpu_lsu i_lsu (
		.clock(clock),
		.rst_n(rst_n),
		.ctrl(ctrl_if.datapath),
		.ex_result(ex_result),
		.ex_store_data(ex_store_data),
		.dmem_valid(dmem_valid),
		.dmem_ready(dmem_ready),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.mem_fwd_data(mem_fwd_data),
		.wb_fwd_data(wb_fwd_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

endmodule

// ==== verilog/cpu_control.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_control (
	input logic clock,
	input logic rst_n,
	cpu_ctrl_if.control ctrl
);
	import cpu_pkg::*;

	logic [`CPU_OP_W-1:0] opcode;
	logic [`CPU_SUB_W-1:0] sub_op;
	logic uses_a;
	logic uses_b;
	logic load_use;

	// nearest older writer wins
	function automatic logic [`CPU_FWD_W-1:0] fwd_sel(input logic [`CPU_REG_ADDR_W-1:0] src);
		if (src == '0)
			return `CPU_FWD_RF;
		if (ctrl.ex_valid && ctrl.ex_reg_write && ctrl.ex_dest == src)
			return `CPU_FWD_MEM;
		if (ctrl.mem_valid && ctrl.mem_reg_write && ctrl.mem_dest == src)
			return `CPU_FWD_WB;
		return `CPU_FWD_RF;
	endfunction

	assign opcode = ctrl.de_instr.r_form.opcode;
	assign sub_op = ctrl.de_instr.r_form.sub_op;
	assign ctrl.rs_a = ctrl.de_instr.r_form.ra;
	assign ctrl.dec_dest = ctrl.de_instr.r_form.rt;

	always_comb begin
		ctrl.dec_alu_op = `CPU_SUB_ADD;
		ctrl.dec_imm_sel = 1'b0;
		ctrl.dec_mem_read = 1'b0;
		ctrl.dec_mem_write = 1'b0;
		ctrl.dec_reg_write = 1'b0;
		ctrl.dec_branch = 1'b0;
		ctrl.dec_bne = 1'b0;
		ctrl.rs_b = ctrl.de_instr.r_form.rt;
		uses_a = 1'b1;
		uses_b = 1'b0;
		case (opcode)
			`CPU_OP_ALU: begin
				ctrl.dec_alu_op = sub_op;
				ctrl.dec_reg_write = 1'b1;
				ctrl.rs_b = ctrl.de_instr.r_form.rb;
				uses_b = 1'b1;
			end
			`CPU_OP_ADDI: begin
				ctrl.dec_imm_sel = 1'b1;
				ctrl.dec_reg_write = 1'b1;
			end
			`CPU_OP_LW: begin
				ctrl.dec_imm_sel = 1'b1;
				ctrl.dec_mem_read = 1'b1;
				ctrl.dec_reg_write = 1'b1;
			end
			`CPU_OP_SW: begin
				// rt is the store data
				ctrl.dec_imm_sel = 1'b1;
				ctrl.dec_mem_write = 1'b1;
				uses_b = 1'b1;
			end
			`CPU_OP_BEQ, `CPU_OP_BNE: begin
				ctrl.dec_alu_op = `CPU_SUB_SUB;
				ctrl.dec_branch = 1'b1;
				ctrl.dec_bne = (opcode == `CPU_OP_BNE);
				uses_b = 1'b1;
			end
			default: begin
				uses_a = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl.fwd_a = fwd_sel(ctrl.rs_a);
		ctrl.fwd_b = fwd_sel(ctrl.rs_b);
	end

	// load in execute feeding the decoding instruction
	assign load_use = ctrl.de_valid && ctrl.ex_valid && ctrl.ex_load && ctrl.ex_dest != '0 &&
		((uses_a && ctrl.ex_dest == ctrl.rs_a) || (uses_b && ctrl.ex_dest == ctrl.rs_b));

	assign ctrl.stall_fetch = load_use;
	assign ctrl.bubble_ex = load_use || ctrl.branch_taken;
	assign ctrl.flush = ctrl.branch_taken;
	assign ctrl.hold = ctrl.mem_busy || ctrl.if_busy;

	a_stall_vs_branch: assert property (@(posedge clock) disable iff (!rst_n)
		!ctrl.hold |-> !(ctrl.stall_fetch && ctrl.branch_taken));

	a_fwd_not_r0: assert property (@(posedge clock) disable iff (!rst_n)
		(ctrl.fwd_a != `CPU_FWD_RF |-> ctrl.rs_a != '0) and
		(ctrl.fwd_b != `CPU_FWD_RF |-> ctrl.rs_b != '0));

endmodule

// ==== verilog/cpu_ctrl_if.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

interface cpu_ctrl_if;
	import cpu_pkg::*;

	// from control
	logic stall_fetch;
	logic bubble_ex;
	logic flush;
	logic hold;
	logic [`CPU_SUB_W-1:0] dec_alu_op;
	logic dec_imm_sel;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_reg_write;
	logic dec_branch;
	logic dec_bne;
	logic [`CPU_REG_ADDR_W-1:0] dec_dest;
	logic [`CPU_REG_ADDR_W-1:0] rs_a;
	logic [`CPU_REG_ADDR_W-1:0] rs_b;
	logic [`CPU_FWD_W-1:0] fwd_a;
	logic [`CPU_FWD_W-1:0] fwd_b;

	// from the datapath
	instr_t de_instr;
	logic [`CPU_XLEN-1:0] de_pc;
	logic de_valid;
	logic [`CPU_REG_ADDR_W-1:0] ex_dest;
	logic ex_reg_write;
	logic ex_load;
	logic ex_valid;
	logic [`CPU_REG_ADDR_W-1:0] mem_dest;
	logic mem_reg_write;
	logic mem_load;
	logic mem_store;
	logic mem_valid;
	logic branch_taken;
	logic mem_busy;
	logic if_busy;

	modport control (
		output stall_fetch, bubble_ex, flush, hold,
		output dec_alu_op, dec_imm_sel, dec_mem_read, dec_mem_write,
		output dec_reg_write, dec_branch, dec_bne, dec_dest,
		output rs_a, rs_b, fwd_a, fwd_b,
		input  de_instr, de_valid,
		input  ex_dest, ex_reg_write, ex_load, ex_valid,
		input  mem_dest, mem_reg_write, mem_load, mem_valid,
		input  branch_taken, mem_busy, if_busy
	);

	modport datapath (
		input  stall_fetch, bubble_ex, flush, hold,
		input  dec_alu_op, dec_imm_sel, dec_mem_read, dec_mem_write,
		input  dec_reg_write, dec_branch, dec_bne, dec_dest,
		input  fwd_a, fwd_b,
		output de_instr, de_pc, de_valid,
		output ex_dest, ex_reg_write, ex_load, ex_valid,
		output mem_dest, mem_reg_write, mem_load, mem_store, mem_valid,
		output branch_taken, mem_busy, if_busy
	);

endinterface

// ==== verilog/cpu_execute.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_execute (
	input logic clock,
	input logic rst_n,
	cpu_ctrl_if.datapath ctrl,
	input logic [`CPU_XLEN-1:0] rd_a_data,
	input logic [`CPU_XLEN-1:0] rd_b_data,
	input logic [`CPU_XLEN-1:0] mem_fwd_data,
	input logic [`CPU_XLEN-1:0] wb_fwd_data,
	output logic [`CPU_XLEN-1:0] branch_target,
	output logic alu_overflow,
	output logic [`CPU_XLEN-1:0] ex_result,
	output logic [`CPU_XLEN-1:0] ex_store_data
);
	import cpu_pkg::*;

	localparam int XLEN = `CPU_XLEN;

	// decode/execute slot
	instr_t ex_instr;
	logic [XLEN-1:0] ex_pc;
	logic [XLEN-1:0] ex_a_data;
	logic [XLEN-1:0] ex_b_data;
	logic [`CPU_SUB_W-1:0] ex_alu_op;
	logic ex_imm_sel;
	logic ex_mem_write;
	logic ex_branch;
	logic ex_bne;
	logic [`CPU_FWD_W-1:0] ex_fwd_a;
	logic [`CPU_FWD_W-1:0] ex_fwd_b;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_res;
	logic ovf;

	function automatic logic [XLEN-1:0] pick(input logic [`CPU_FWD_W-1:0] sel,
		input logic [XLEN-1:0] rf_data);
		case (sel)
			`CPU_FWD_MEM: return mem_fwd_data;
			`CPU_FWD_WB:  return wb_fwd_data;
			default:      return rf_data;
		endcase
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.ex_valid <= 1'b0;
			ctrl.ex_reg_write <= 1'b0;
			ctrl.ex_load <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= 1'b0;
			ctrl.mem_valid <= 1'b0;
			ctrl.mem_reg_write <= 1'b0;
			ctrl.mem_load <= 1'b0;
			ctrl.mem_store <= 1'b0;
		end else if (!ctrl.hold) begin
			ctrl.ex_valid <= ctrl.de_valid && !ctrl.bubble_ex;
			ctrl.ex_reg_write <= ctrl.dec_reg_write;
			ctrl.ex_load <= ctrl.dec_mem_read;
			ex_mem_write <= ctrl.dec_mem_write;
			ex_branch <= ctrl.dec_branch;
			ctrl.mem_valid <= ctrl.ex_valid;
			ctrl.mem_reg_write <= ctrl.ex_reg_write;
			ctrl.mem_load <= ctrl.ex_load;
			ctrl.mem_store <= ex_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (!ctrl.hold) begin
			ex_instr <= ctrl.de_instr;
			ex_pc <= ctrl.de_pc;
			ex_a_data <= rd_a_data;
			ex_b_data <= rd_b_data;
			ex_alu_op <= ctrl.dec_alu_op;
			ex_imm_sel <= ctrl.dec_imm_sel;
			ex_bne <= ctrl.dec_bne;
			ex_fwd_a <= ctrl.fwd_a;
			ex_fwd_b <= ctrl.fwd_b;
			ctrl.ex_dest <= ctrl.dec_dest;
			ctrl.mem_dest <= ctrl.ex_dest;
			ex_result <= alu_res;
			ex_store_data <= op_b;
		end
	end

	assign op_a = pick(ex_fwd_a, ex_a_data);
	assign op_b = pick(ex_fwd_b, ex_b_data);
	assign imm_ext = {{(XLEN-15){ex_instr.i_form.imm15[14]}}, ex_instr.i_form.imm15};
	assign src2 = ex_imm_sel ? imm_ext : op_b;

	always_comb begin
		alu_res = '0;
		ovf = 1'b0;
		case (ex_alu_op)
			`CPU_SUB_ADD: begin
				alu_res = op_a + src2;
				ovf = (op_a[XLEN-1] == src2[XLEN-1]) && (alu_res[XLEN-1] != op_a[XLEN-1]);
			end
			`CPU_SUB_SUB: begin
				alu_res = op_a - src2;
				ovf = (op_a[XLEN-1] != src2[XLEN-1]) && (alu_res[XLEN-1] != op_a[XLEN-1]);
			end
			`CPU_SUB_AND: alu_res = op_a & src2;
			`CPU_SUB_OR:  alu_res = op_a | src2;
			`CPU_SUB_XOR: alu_res = op_a ^ src2;
			`CPU_SUB_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(src2)};
			default: alu_res = '0;
		endcase
	end

	// rt against ra
	assign ctrl.branch_taken = ctrl.ex_valid && ex_branch && ((op_a == op_b) != ex_bne);
	assign branch_target = ex_pc + (imm_ext << 2);

	// only add, sub and addi count, on the cycle the slot moves on
	assign alu_overflow = ctrl.ex_valid && ctrl.ex_reg_write && !ctrl.ex_load && ovf &&
		!ctrl.hold;

endmodule

// ==== verilog/cpu_fetch.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_fetch (
	input logic clock,
	input logic rst_n,
	cpu_ctrl_if.datapath ctrl,
	input logic [`CPU_XLEN-1:0] branch_target,
	output logic imem_valid,
	input logic imem_ready,
	output logic [`CPU_XLEN-1:0] imem_addr,
	input logic [`CPU_XLEN-1:0] imem_rdata
);
	logic [`CPU_XLEN-1:0] pc;
	logic running;
	logic ibuf_valid;
	logic [`CPU_XLEN-1:0] ibuf;
	logic xfer;
	logic fetched;
	logic advance;

	// a word already taken while the pipeline held waits in ibuf
	assign imem_valid = running && !ibuf_valid;
	assign imem_addr = pc;
	assign xfer = imem_valid && imem_ready;
	assign fetched = ibuf_valid || xfer;
	assign advance = !ctrl.hold && !ctrl.stall_fetch;
	assign ctrl.if_busy = imem_valid && !imem_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			pc <= `CPU_RESET_PC;
			ibuf_valid <= 1'b0;
			ctrl.de_valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (!ctrl.hold && ctrl.flush) begin
				// wrong-path word is dropped
				pc <= branch_target;
				ibuf_valid <= 1'b0;
				ctrl.de_valid <= 1'b0;
			end else if (advance) begin
				if (fetched)
					pc <= pc + `CPU_XLEN'd4;
				ibuf_valid <= 1'b0;
				ctrl.de_valid <= fetched;
			end else if (xfer) begin
				ibuf_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (xfer)
			ibuf <= imem_rdata;
		if (advance && !ctrl.flush && fetched) begin
			ctrl.de_instr <= ibuf_valid ? ibuf : imem_rdata;
			ctrl.de_pc <= pc;
		end
	end

	a_imem_stable: assert property (@(posedge clock) disable iff (!rst_n)
		imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr));

endmodule

// ==== verilog/cpu_lsu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_lsu (
	input logic clock,
	input logic rst_n,
	cpu_ctrl_if.datapath ctrl,
	input logic [`CPU_XLEN-1:0] ex_result,
	input logic [`CPU_XLEN-1:0] ex_store_data,
	output logic dmem_valid,
	input logic dmem_ready,
	output logic dmem_write,
	output logic [`CPU_XLEN-1:0] dmem_addr,
	output logic [`CPU_XLEN-1:0] dmem_wdata,
	input logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic [`CPU_XLEN-1:0] mem_fwd_data,
	output logic [`CPU_XLEN-1:0] wb_fwd_data,
	output logic wr_en,
	output logic [`CPU_REG_ADDR_W-1:0] wr_addr,
	output logic [`CPU_XLEN-1:0] wr_data
);
	logic mem_op;
	logic done;
	logic xfer;
	logic [`CPU_XLEN-1:0] ld_buf;
	logic [`CPU_XLEN-1:0] ld_data;

	assign mem_op = ctrl.mem_valid && (ctrl.mem_load || ctrl.mem_store);

	// access finished while fetch still holds the pipe
	assign dmem_valid = mem_op && !done;
	assign dmem_write = ctrl.mem_store;
	assign dmem_addr = ex_result;
	assign dmem_wdata = ex_store_data;
	assign xfer = dmem_valid && dmem_ready;
	assign ctrl.mem_busy = dmem_valid && !dmem_ready;
	assign ld_data = done ? ld_buf : dmem_rdata;

	assign mem_fwd_data = ex_result;
	assign wb_fwd_data = wr_data;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			if (!ctrl.hold)
				done <= 1'b0;
			else if (xfer)
				done <= 1'b1;
			if (!ctrl.hold)
				wr_en <= ctrl.mem_valid && ctrl.mem_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (xfer)
			ld_buf <= dmem_rdata;
		if (!ctrl.hold) begin
			wr_addr <= ctrl.mem_dest;
			wr_data <= ctrl.mem_load ? ld_data : ex_result;
		end
	end

	a_dmem_hold: assert property (@(posedge clock) disable iff (!rst_n)
		dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr));

endmodule

// ==== verilog/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

	// one instruction word, two field layouts
	typedef union packed {
		struct packed {
			logic                       rsv_hi;
			logic [`CPU_OP_W-1:0]       opcode;
			logic [`CPU_REG_ADDR_W-1:0] rt;
			logic [`CPU_REG_ADDR_W-1:0] ra;
			logic [`CPU_REG_ADDR_W-1:0] rb;
			logic [4:0]                 rsv_lo;
			logic [`CPU_SUB_W-1:0]      sub_op;
		} r_form;
		struct packed {
			logic                       rsv_hi;
			logic [`CPU_OP_W-1:0]       opcode;
			logic [`CPU_REG_ADDR_W-1:0] rt;
			logic [`CPU_REG_ADDR_W-1:0] ra;
			logic [14:0]                imm15;
		} i_form;
	} instr_t;

endpackage

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_regfile (
	input logic clock,
	input logic rst_n,
	input logic [`CPU_REG_ADDR_W-1:0] rd_a_addr,
	input logic [`CPU_REG_ADDR_W-1:0] rd_b_addr,
	output logic [`CPU_XLEN-1:0] rd_a_data,
	output logic [`CPU_XLEN-1:0] rd_b_data,
	input logic wr_en,
	input logic [`CPU_REG_ADDR_W-1:0] wr_addr,
	input logic [`CPU_XLEN-1:0] wr_data
);
	// r0 has no storage
	logic [`CPU_XLEN-1:0] regs [1:`CPU_NREG-1];

	// same-cycle write is seen by the read
	function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && wr_addr == addr)
			return wr_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `CPU_NREG; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rd_a_data = read_port(rd_a_addr);
		rd_b_data = read_port(rd_b_addr);
	end

endmodule
